/* common/clk_meas_config.svh */
/*
 * clock measurement configuration
 * widths, window length, timeout limit and synchronizer depth
 */
`ifndef CLK_MEAS_CONFIG_SVH
`define CLK_MEAS_CONFIG_SVH

// width of the source-cycle count and of the software limits
`define CLK_MEAS_CNT_W 6

// reference edges per measurement window
`define CLK_MEAS_REF_CNT 1

// source cycles without a reference edge before a timeout is raised
`define CLK_MEAS_TIMEOUT 48

// flops in each clock domain crossing synchronizer
`define CLK_MEAS_SYNC_STAGES 2

`endif

/* common/clk_meas_pkg.sv */
/*
 * clock measurement package
 * multi-bit boolean encoding, its helpers and the window result type
 */
package clk_meas_pkg;

  // 4-bit multi-bit boolean, only A and 5 are legal values
  typedef logic [3:0] mubi4_t;

  localparam mubi4_t MUBI4_TRUE  = 4'hA;
  localparam mubi4_t MUBI4_FALSE = 4'h5;

  // per-window result, all fields are single-cycle pulses
  typedef struct packed {
    logic done;
    logic fast;
    logic slow;
  } meas_result_t;

  // anything other than a clean false reads as true
  function automatic logic mubi4_test_true_loose(mubi4_t val);
    return val != MUBI4_FALSE;
  endfunction

  // only an exact false encoding reads as false
  function automatic logic mubi4_test_false_strict(mubi4_t val);
    return val == MUBI4_FALSE;
  endfunction

  // neither legal encoding
  function automatic logic mubi4_test_invalid(mubi4_t val);
    return (val != MUBI4_TRUE) && (val != MUBI4_FALSE);
  endfunction

endpackage

/* common/meas_ctrl_if.sv */
/*
 * measurement control interface
 * source-domain enable and limits toward the counter, window results back
 */
`timescale 1ns/1ps
`include "clk_meas_config.svh"

interface meas_ctrl_if
  import clk_meas_pkg::*;
();

  // measurement enable, all on the source clock
  logic                       en;
  // window limits, inclusive
  logic [`CLK_MEAS_CNT_W-1:0] max_cnt;
  logic [`CLK_MEAS_CNT_W-1:0] min_cnt;
  // done/fast/slow pulses at each window end
  meas_result_t               result;

  // checker side
  modport ctrl (
    output en,
    output max_cnt,
    output min_cnt,
    input  result
  );

  // counter side
  modport meas (
    input  en,
    input  max_cnt,
    input  min_cnt,
    output result
  );

endinterface

/* hdl/sync_2ff.sv */
/*
 * multi-flop synchronizer
 * carries any payload type into the clock domain of clk_i
 */
`timescale 1ns/1ps
`include "clk_meas_config.svh"

module sync_2ff #(
  parameter type T         = logic,
  parameter T    RESET_VAL = '0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     d_i,
  output T     q_o
);

  localparam int STAGES = `CLK_MEAS_SYNC_STAGES;

  // stage 0 samples the asynchronous input
  T stage_q [STAGES];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < STAGES; i++) begin
        stage_q[i] <= RESET_VAL;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // last stage is the settled value
  assign q_o = stage_q[STAGES-1];

endmodule

/* hdl/reqack_sync.sv */
/*
 * four-phase req/ack pulse synchronizer
 * one destination pulse per completed source request
 */
`timescale 1ns/1ps

module reqack_sync (
  input  logic clk_src_i,
  input  logic rst_src_ni,
  input  logic clk_dst_i,
  input  logic rst_dst_ni,
  input  logic src_req_i,
  output logic src_ack_o,
  output logic dst_pulse_o
);

  logic dst_req;
  logic dst_ack_q;

  // request into the destination domain
  sync_2ff #(
    .T         (logic),
    .RESET_VAL (1'b0)
  ) u_req_sync (
    .clk_i  (clk_dst_i),
    .rst_ni (rst_dst_ni),
    .d_i    (src_req_i),
    .q_o    (dst_req)
  );

  // ack follows the synchronized request
  // rises once req is seen, drops once req is gone
  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      dst_ack_q <= 1'b0;
    end else begin
      dst_ack_q <= dst_req;
    end
  end

  // the cycle in which ack is about to rise
  assign dst_pulse_o = dst_req & ~dst_ack_q;

  // ack back into the source domain
  sync_2ff #(
    .T         (logic),
    .RESET_VAL (1'b0)
  ) u_ack_sync (
    .clk_i  (clk_src_i),
    .rst_ni (rst_src_ni),
    .d_i    (dst_ack_q),
    .q_o    (src_ack_o)
  );

  // req may only fall after the ack came back
  req_held_until_ack_a: assert property (
    @(posedge clk_src_i) disable iff (!rst_src_ni)
    (src_req_i && !src_ack_o) |=> src_req_i
  ) else $error("reqack_sync: req dropped before ack");

  // a new req waits for the previous ack to clear
  req_waits_ack_low_a: assert property (
    @(posedge clk_src_i) disable iff (!rst_src_ni)
    (!src_req_i && src_ack_o) |=> !src_req_i
  ) else $error("reqack_sync: req raised while ack still high");

endmodule

/* clk_meas/clk_meas_counter.sv */
/*
 * clock measurement counter
 * counts source cycles per reference window, checks them against the
 * software limits and raises a timeout when the reference goes quiet
 */
`timescale 1ns/1ps
`include "clk_meas_config.svh"

module clk_meas_counter
  import clk_meas_pkg::*;
(
  input  logic      clk_src_i,
  input  logic      rst_src_ni,
  input  logic      clk_ref_i,
  input  logic      rst_ref_ni,
  meas_ctrl_if.meas ctrl,
  output logic      timeout_o
);

  localparam int                CNT_W     = `CLK_MEAS_CNT_W;
  localparam int                REF_CNT_W = $clog2(`CLK_MEAS_REF_CNT + 1);
  localparam logic [CNT_W-1:0]  CNT_MAX   = '1;
  localparam logic [CNT_W-1:0]  TIMEOUT   = CNT_W'(`CLK_MEAS_TIMEOUT);
  localparam logic [REF_CNT_W-1:0] REF_LAST = REF_CNT_W'(`CLK_MEAS_REF_CNT - 1);

  logic                 ref_tgl_q;
  logic                 ref_tgl_sync;
  logic                 ref_tgl_dly_q;
  logic                 ref_edge;
  logic                 window_end;
  logic                 armed_q;
  logic [CNT_W-1:0]     cnt_q;
  logic [REF_CNT_W-1:0] ref_cnt_q;
  logic                 timeout_q;
  meas_result_t         result_q;

  // toggles once per reference edge, slow enough to sync as a level
  always_ff @(posedge clk_ref_i or negedge rst_ref_ni) begin
    if (!rst_ref_ni) begin
      ref_tgl_q <= 1'b0;
    end else begin
      ref_tgl_q <= ~ref_tgl_q;
    end
  end

  sync_2ff #(
    .T         (logic),
    .RESET_VAL (1'b0)
  ) u_ref_sync (
    .clk_i  (clk_src_i),
    .rst_ni (rst_src_ni),
    .d_i    (ref_tgl_q),
    .q_o    (ref_tgl_sync)
  );

  // delayed copy for the edge compare
  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      ref_tgl_dly_q <= 1'b0;
    end else begin
      ref_tgl_dly_q <= ref_tgl_sync;
    end
  end

  assign ref_edge   = ref_tgl_sync ^ ref_tgl_dly_q;
  // window closes on the last reference edge of the window
  assign window_end = ref_edge && (ref_cnt_q == REF_LAST);

  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      cnt_q     <= '0;
      ref_cnt_q <= '0;
      armed_q   <= 1'b0;
      timeout_q <= 1'b0;
      result_q  <= '0;
    end else if (!ctrl.en) begin
      // disabled, hold everything idle
      cnt_q     <= '0;
      ref_cnt_q <= '0;
      armed_q   <= 1'b0;
      timeout_q <= 1'b0;
      result_q  <= '0;
    end else begin
      result_q <= '0;
      // timeout holds until a reference edge shows up
      if (ref_edge) begin
        timeout_q <= 1'b0;
      end else if (cnt_q == TIMEOUT) begin
        timeout_q <= 1'b1;
      end
      if (!armed_q) begin
        // first edge after enable only opens a window
        if (ref_edge) begin
          armed_q   <= 1'b1;
          cnt_q     <= CNT_W'(1);
          ref_cnt_q <= '0;
        end else if (cnt_q != CNT_MAX) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else if (window_end) begin
        result_q.done <= 1'b1;
        result_q.fast <= cnt_q > ctrl.max_cnt;
        result_q.slow <= cnt_q < ctrl.min_cnt;
        cnt_q         <= CNT_W'(1);
        ref_cnt_q     <= '0;
      end else begin
        if (ref_edge) begin
          ref_cnt_q <= ref_cnt_q + 1'b1;
        end
        // saturate rather than wrap
        if (cnt_q != CNT_MAX) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign ctrl.result = result_q;
  assign timeout_o   = timeout_q;

  // fast and slow only with done, never together
  result_onehot_a: assert property (
    @(posedge clk_src_i) disable iff (!rst_src_ni)
    (ctrl.result.fast || ctrl.result.slow) |->
      (ctrl.result.done && !(ctrl.result.fast && ctrl.result.slow))
  ) else $error("clk_meas_counter: fast and slow set together");

endmodule

/* clk_meas/clk_meas_chk.sv */
/*
 * clock measurement check
 * runs the window counter, moves its errors to the local clock and
 * drops the measurement enable when calibration is lost
 */
`timescale 1ns/1ps
`include "clk_meas_config.svh"

module clk_meas_chk
  import clk_meas_pkg::*;
(
  // local operating clock
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // measured clock
  input  logic                       clk_src_i,
  input  logic                       rst_src_ni,
  // reference clock
  input  logic                       clk_ref_i,
  input  logic                       rst_ref_ni,
  // controls, on the source clock
  input  logic                       src_en_i,
  input  logic [`CLK_MEAS_CNT_W-1:0] src_max_cnt_i,
  input  logic [`CLK_MEAS_CNT_W-1:0] src_min_cnt_i,
  input  mubi4_t                     src_cfg_meas_en_i,
  output logic                       src_cfg_meas_en_valid_o,
  output mubi4_t                     src_cfg_meas_en_o,
  // calibration flag, on the local clock
  input  mubi4_t                     calib_rdy_i,
  // errors, on the local clock
  output logic                       meas_err_o,
  output logic                       timeout_err_o
);

  logic   src_err;
  logic   src_err_req_q;
  logic   src_err_pend_q;
  logic   src_err_ack;
  logic   src_timeout;
  logic   timeout_sync;
  logic   timeout_dly_q;
  mubi4_t src_calib_rdy;

  meas_ctrl_if u_meas_ctrl ();

  assign u_meas_ctrl.en      = src_en_i;
  assign u_meas_ctrl.max_cnt = src_max_cnt_i;
  assign u_meas_ctrl.min_cnt = src_min_cnt_i;

  clk_meas_counter u_counter (
    .clk_src_i  (clk_src_i),
    .rst_src_ni (rst_src_ni),
    .clk_ref_i  (clk_ref_i),
    .rst_ref_ni (rst_ref_ni),
    .ctrl       (u_meas_ctrl.meas),
    .timeout_o  (src_timeout)
  );

  // calibration flag into the source domain, lost until proven ready
  sync_2ff #(
    .T         (mubi4_t),
    .RESET_VAL (MUBI4_FALSE)
  ) u_calib_sync (
    .clk_i  (clk_src_i),
    .rst_ni (rst_src_ni),
    .d_i    (calib_rdy_i),
    .q_o    (src_calib_rdy)
  );

  // pass through unless calibration is lost while enabled
  always_comb begin
    src_cfg_meas_en_valid_o = 1'b0;
    src_cfg_meas_en_o       = src_cfg_meas_en_i;
    if (mubi4_test_false_strict(src_calib_rdy) &&
        mubi4_test_true_loose(src_cfg_meas_en_i)) begin
      src_cfg_meas_en_valid_o = 1'b1;
      src_cfg_meas_en_o       = MUBI4_FALSE;
    end
  end

  assign src_err = u_meas_ctrl.result.fast | u_meas_ctrl.result.slow;

  // error request, held until ack
  // errors during a live req merge into it
  // errors while ack is still draining wait in pend for the next req
  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      src_err_req_q  <= 1'b0;
      src_err_pend_q <= 1'b0;
    end else if (!src_err_req_q && !src_err_ack && (src_err || src_err_pend_q)) begin
      src_err_req_q  <= 1'b1;
      src_err_pend_q <= 1'b0;
    end else begin
      if (src_err_req_q && src_err_ack) begin
        src_err_req_q <= 1'b0;
      end
      if (src_err && !src_err_req_q) begin
        src_err_pend_q <= 1'b1;
      end
    end
  end

  reqack_sync u_err_sync (
    .clk_src_i   (clk_src_i),
    .rst_src_ni  (rst_src_ni),
    .clk_dst_i   (clk_i),
    .rst_dst_ni  (rst_ni),
    .src_req_i   (src_err_req_q),
    .src_ack_o   (src_err_ack),
    .dst_pulse_o (meas_err_o)
  );

  // timeout is a level, sync it and take the rising edge
  sync_2ff #(
    .T         (logic),
    .RESET_VAL (1'b0)
  ) u_timeout_sync (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (src_timeout),
    .q_o    (timeout_sync)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      timeout_dly_q <= 1'b0;
      timeout_err_o <= 1'b0;
    end else begin
      timeout_dly_q <= timeout_sync;
      timeout_err_o <= timeout_sync & ~timeout_dly_q;
    end
  end

endmodule

/* hdl/clk_meas_top.sv */
/*
 * clock measurement top level
 * exposes the measurement check block on plain ports
 */
`timescale 1ns/1ps
`include "clk_meas_config.svh"

module clk_meas_top
  import clk_meas_pkg::*;
(
  // local operating clock
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // measured clock
  input  logic                       clk_src_i,
  input  logic                       rst_src_ni,
  // reference clock
  input  logic                       clk_ref_i,
  input  logic                       rst_ref_ni,
  // source-domain controls
  input  logic                       src_en_i,
  input  logic [`CLK_MEAS_CNT_W-1:0] src_max_cnt_i,
  input  logic [`CLK_MEAS_CNT_W-1:0] src_min_cnt_i,
  input  mubi4_t                     src_cfg_meas_en_i,
  output logic                       src_cfg_meas_en_valid_o,
  output mubi4_t                     src_cfg_meas_en_o,
  // local-domain calibration flag
  input  mubi4_t                     calib_rdy_i,
  // local-domain error pulses
  output logic                       meas_err_o,
  output logic                       timeout_err_o
);

  clk_meas_chk u_clk_meas_chk (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .clk_src_i               (clk_src_i),
    .rst_src_ni              (rst_src_ni),
    .clk_ref_i               (clk_ref_i),
    .rst_ref_ni              (rst_ref_ni),
    .src_en_i                (src_en_i),
    .src_max_cnt_i           (src_max_cnt_i),
    .src_min_cnt_i           (src_min_cnt_i),
    .src_cfg_meas_en_i       (src_cfg_meas_en_i),
    .src_cfg_meas_en_valid_o (src_cfg_meas_en_valid_o),
    .src_cfg_meas_en_o       (src_cfg_meas_en_o),
    .calib_rdy_i             (calib_rdy_i),
    .meas_err_o              (meas_err_o),
    .timeout_err_o           (timeout_err_o)
  );

endmodule

/* testbench/tb_clk_meas.sv */
/*
 * testbench for the clock measurement top level
 * table driven windows, reference loss, calibration gate and disable
 */
`timescale 1ns/1ps
`include "clk_meas_config.svh"

module tb_clk_meas
  import clk_meas_pkg::*;
();

  localparam int SRC_PERIOD   = 20;
  localparam int LOCAL_PERIOD = 30;
  localparam int NUM_TESTS    = 7;
  localparam int IDLE_CYCLES  = 40;
  localparam int STOP_WAIT    = 200;
  localparam int REF_WAIT     = 8;
  localparam int SEED         = 71570;
  // pulse expectations
  localparam int NONE = 0;
  localparam int ONE  = 1;
  localparam int SOME = 2;

  typedef struct {
    string                      name;
    int                         ref_period;
    logic [`CLK_MEAS_CNT_W-1:0] min_cnt;
    logic [`CLK_MEAS_CNT_W-1:0] max_cnt;
    logic                       src_en;
    mubi4_t                     calib;
    mubi4_t                     meas_en;
    logic                       exp_valid;
    mubi4_t                     exp_en_o;
    int                         exp_meas;
    int                         exp_tmo;
  } test_row_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clk_src_i;
  logic                       rst_src_ni;
  logic                       clk_ref_i;
  logic                       rst_ref_ni;
  logic                       src_en_i;
  logic [`CLK_MEAS_CNT_W-1:0] src_max_cnt_i;
  logic [`CLK_MEAS_CNT_W-1:0] src_min_cnt_i;
  mubi4_t                     src_cfg_meas_en_i;
  logic                       src_cfg_meas_en_valid_o;
  mubi4_t                     src_cfg_meas_en_o;
  mubi4_t                     calib_rdy_i;
  logic                       meas_err_o;
  logic                       timeout_err_o;

  test_row_t rows [NUM_TESTS];
  // reference period in source cycles, 0 stops the reference
  int   ref_period  = 0;
  int   meas_pulses = 0;
  int   tmo_pulses  = 0;
  int   row_errors  = 0;
  logic table_ready = 1'b0;

  clk_meas_top u_clk_meas_top (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .clk_src_i               (clk_src_i),
    .rst_src_ni              (rst_src_ni),
    .clk_ref_i               (clk_ref_i),
    .rst_ref_ni              (rst_ref_ni),
    .src_en_i                (src_en_i),
    .src_max_cnt_i           (src_max_cnt_i),
    .src_min_cnt_i           (src_min_cnt_i),
    .src_cfg_meas_en_i       (src_cfg_meas_en_i),
    .src_cfg_meas_en_valid_o (src_cfg_meas_en_valid_o),
    .src_cfg_meas_en_o       (src_cfg_meas_en_o),
    .calib_rdy_i             (calib_rdy_i),
    .meas_err_o              (meas_err_o),
    .timeout_err_o           (timeout_err_o)
  );

  initial begin
    clk_src_i = 1'b0;
    forever #(SRC_PERIOD / 2) clk_src_i = ~clk_src_i;
  end

  // local clock offset so its edges never meet the source edges
  initial begin
    clk_i = 1'b0;
    #3;
    forever #(LOCAL_PERIOD / 2) clk_i = ~clk_i;
  end

  // reference edges sit 5 ns after a source edge
  initial begin
    clk_ref_i = 1'b0;
    forever begin
      if (ref_period == 0) begin
        @(posedge clk_src_i);
        #5;
      end else begin
        clk_ref_i = 1'b1;
        #(ref_period * SRC_PERIOD / 2);
        clk_ref_i = 1'b0;
        #(ref_period * SRC_PERIOD / 2);
      end
    end
  end

  // local-clock pulses, sampled away from the edge that makes them
  always @(negedge clk_i) begin
    if (meas_err_o === 1'b1) meas_pulses = meas_pulses + 1;
    if (timeout_err_o === 1'b1) tmo_pulses = tmo_pulses + 1;
  end

  function automatic test_row_t make_row(string name, int ref_per, int min_cnt,
                                         int max_cnt, logic src_en, mubi4_t calib,
                                         mubi4_t meas_en, logic exp_valid,
                                         mubi4_t exp_en_o, int exp_meas, int exp_tmo);
    test_row_t row;
    row.name       = name;
    row.ref_period = ref_per;
    row.min_cnt    = min_cnt[`CLK_MEAS_CNT_W-1:0];
    row.max_cnt    = max_cnt[`CLK_MEAS_CNT_W-1:0];
    row.src_en     = src_en;
    row.calib      = calib;
    row.meas_en    = meas_en;
    row.exp_valid  = exp_valid;
    row.exp_en_o   = exp_en_o;
    row.exp_meas   = exp_meas;
    row.exp_tmo    = exp_tmo;
    return row;
  endfunction

  // count of 16 sits inside 14..18, 24 is above, 10 below
  task automatic load_table();
    rows[0] = make_row("in_range", 16, 14, 18, 1'b1, MUBI4_TRUE, MUBI4_TRUE,
                       1'b0, MUBI4_TRUE, NONE, NONE);
    rows[1] = make_row("too_fast", 24, 14, 18, 1'b1, MUBI4_TRUE, MUBI4_TRUE,
                       1'b0, MUBI4_TRUE, SOME, NONE);
    rows[2] = make_row("too_slow", 10, 14, 18, 1'b1, MUBI4_TRUE, MUBI4_TRUE,
                       1'b0, MUBI4_TRUE, SOME, NONE);
    rows[3] = make_row("ref_stopped", 0, 14, 18, 1'b1, MUBI4_TRUE, MUBI4_TRUE,
                       1'b0, MUBI4_TRUE, NONE, ONE);
    rows[4] = make_row("calib_lost", 16, 14, 18, 1'b1, MUBI4_FALSE, MUBI4_TRUE,
                       1'b1, MUBI4_FALSE, NONE, NONE);
    rows[5] = make_row("calib_ready", 16, 14, 18, 1'b1, MUBI4_TRUE, MUBI4_TRUE,
                       1'b0, MUBI4_TRUE, NONE, NONE);
    // limits that would fail if the counter ran
    rows[6] = make_row("disabled", 24, 14, 18, 1'b0, MUBI4_TRUE, MUBI4_TRUE,
                       1'b0, MUBI4_TRUE, NONE, NONE);
  endtask

  function automatic int row_wait_cycles(test_row_t row);
    return (row.ref_period == 0) ? STOP_WAIT : REF_WAIT * row.ref_period;
  endfunction

  task automatic check_pulses(int test_no, string sig, int got, int mode);
    case (mode)
      NONE: assert (got == 0) else begin
        $display("ERROR test %0d %s: got 0x%0h pulses, expected 0x0", test_no, sig, got);
        row_errors++;
      end
      ONE: assert (got == 1) else begin
        $display("ERROR test %0d %s: got 0x%0h pulses, expected 0x1", test_no, sig, got);
        row_errors++;
      end
      default: assert (got >= 1) else begin
        $display("ERROR test %0d %s: got 0x%0h pulses, expected at least 0x1",
                 test_no, sig, got);
        row_errors++;
      end
    endcase
  endtask

  // watchdog sized from the table, twice the planned run
  initial begin
    time limit_ns;
    wait (table_ready);
    limit_ns = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit_ns += (row_wait_cycles(rows[i]) + IDLE_CYCLES + 4) * SRC_PERIOD;
    end
    limit_ns = limit_ns * 2;
    #(limit_ns);
    $display("watchdog expired at %0t, the tests did not complete", $time);
    $display("sim failed");
    $finish;
  end

  initial begin
    int jitter;
    int meas_start;
    int tmo_start;
    int meas_got;
    int tmo_got;
    int passed;
    int failed;
    passed            = 0;
    failed            = 0;
    rst_ni            = 1'b0;
    rst_src_ni        = 1'b0;
    rst_ref_ni        = 1'b0;
    src_en_i          = 1'b0;
    src_max_cnt_i     = '0;
    src_min_cnt_i     = '0;
    src_cfg_meas_en_i = MUBI4_TRUE;
    calib_rdy_i       = MUBI4_TRUE;
    void'($urandom(SEED));
    load_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk_src_i);
    rst_ni     <= 1'b1;
    rst_src_ni <= 1'b1;
    rst_ref_ni <= 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      // idle gap, disabled while the reference settles and errors drain
      jitter = int'($urandom % 4);
      @(posedge clk_src_i);
      src_en_i   <= 1'b0;
      ref_period <= rows[i].ref_period;
      repeat (IDLE_CYCLES + jitter) @(posedge clk_src_i);
      src_en_i          <= rows[i].src_en;
      src_min_cnt_i     <= rows[i].min_cnt;
      src_max_cnt_i     <= rows[i].max_cnt;
      src_cfg_meas_en_i <= rows[i].meas_en;
      calib_rdy_i       <= rows[i].calib;
      meas_start = meas_pulses;
      tmo_start  = tmo_pulses;
      repeat (row_wait_cycles(rows[i])) @(posedge clk_src_i);
      // source outputs settle mid cycle
      @(negedge clk_src_i);
      row_errors = 0;
      meas_got   = meas_pulses - meas_start;
      tmo_got    = tmo_pulses - tmo_start;
      assert (src_cfg_meas_en_valid_o === rows[i].exp_valid) else begin
        $display("ERROR test %0d src_cfg_meas_en_valid_o: got 0x%0h, expected 0x%0h",
                 i + 1, src_cfg_meas_en_valid_o, rows[i].exp_valid);
        row_errors++;
      end
      assert (src_cfg_meas_en_o === rows[i].exp_en_o) else begin
        $display("ERROR test %0d src_cfg_meas_en_o: got 0x%0h, expected 0x%0h",
                 i + 1, src_cfg_meas_en_o, rows[i].exp_en_o);
        row_errors++;
      end
      check_pulses(i + 1, "meas_err_o", meas_got, rows[i].exp_meas);
      check_pulses(i + 1, "timeout_err_o", tmo_got, rows[i].exp_tmo);
      if (row_errors == 0) passed++;
      else failed++;
      $display("test %0d %s %s  meas_err pulses %0d, timeout_err pulses %0d",
               i + 1, rows[i].name, (row_errors == 0) ? "ok" : "FAIL", meas_got, tmo_got);
    end
    $display("%0d tests run, %0d ok, %0d failing", NUM_TESTS, passed, failed);
    if (failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* clk_meas.f */
+incdir+common
common/clk_meas_pkg.sv
common/meas_ctrl_if.sv
hdl/sync_2ff.sv
hdl/reqack_sync.sv
clk_meas/clk_meas_counter.sv
clk_meas/clk_meas_chk.sv
hdl/clk_meas_top.sv
testbench/tb_clk_meas.sv

/* Makefile */
# Verilator build and run for the clock measurement testbench

BIN  := obj_dir/Vtb_clk_meas
SRCS := $(filter-out +incdir+%,$(shell cat clk_meas.f))

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
$(BIN): clk_meas.f $(SRCS) common/clk_meas_config.svh
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f clk_meas.f --top-module tb_clk_meas -o Vtb_clk_meas

sim.log: $(BIN)
	./$(BIN) | tee sim.log

run: sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
